// File: design/heapOpsPkg.sv
//--------------------------------------------------------------------------
// Heap dimensions, operation codes and error codes shared by every block
//--------------------------------------------------------------------------
package heapOpsPkg;

  localparam int ArrayBits = 4;                     // 16 arrays
  localparam int IndexBits = 3;                     // 8 elements per array
  localparam int DataBits  = 12;                    // Element width
  localparam int TagBits   = 6;                     // Request tag width

  localparam int ArrayLength = 1 << IndexBits;      // Elements per array

  //--------------------------------------------------------------------------
  // Operation codes keep the historical numbering of the heap
  //--------------------------------------------------------------------------
  typedef enum logic [4:0] {
    OpWrite = 5'd2,                                 // Store an element
    OpRead  = 5'd3,                                 // Fetch an element
    OpSize  = 5'd4,                                 // Current array size
    OpPush  = 5'd14,                                // Append at the end
    OpPop   = 5'd15,                                // Remove from the end
    OpAlloc = 5'd18,                                // Claim a free array
    OpFree  = 5'd19,                                // Release an array
    OpAdd   = 5'd20                                 // Add, return new value
  } heapOp;

  //--------------------------------------------------------------------------
  // Error codes returned with every response
  //--------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ErrNone         = 3'd0,
    ErrNotAllocated = 3'd1,                         // Array is free
    ErrBounds       = 3'd2,                         // Index not below size
    ErrFull         = 3'd3,                         // Push on full array
    ErrEmpty        = 3'd4,                         // Pop on empty array
    ErrNoMemory     = 3'd5                          // No free array left
  } heapErr;

endpackage

// File: design/heapLinkPkg.sv
//--------------------------------------------------------------------------
// Request and response structs carried on the links between heap blocks
//--------------------------------------------------------------------------
package heapLinkPkg;
  import heapOpsPkg::*;

  // Request as issued by the requester
  typedef struct packed {
    logic [TagBits-1:0]   tag;                      // Returned with the response
    heapOp                op;
    logic [ArrayBits-1:0] array;                    // Array number
    logic [IndexBits-1:0] index;                    // Element index
    logic [DataBits-1:0]  data;                     // Operand
  } heapReq;

  // Request on its way to a bank, with any error found by the dispatcher
  typedef struct packed {
    heapReq req;
    heapErr err;                                    // Bank only echoes this if set
  } bankReq;

  // Response on the bank, merge and external links
  typedef struct packed {
    logic [TagBits-1:0]  tag;
    logic [DataBits-1:0] data;
    heapErr              err;
  } heapRsp;

endpackage

// File: design/creditFifo.sv
//--------------------------------------------------------------------------
// Circular-buffer FIFO for any payload type
// Pulses a credit back to the sender for every entry popped
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module creditFifo #(
  parameter type payloadT = logic [7:0],
  parameter int  Depth    = 4
) (
  input  logic    clock,
  input  logic    resetN,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    notEmpty,
  output logic    credit
);

  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntBits = $clog2(Depth + 1);

  payloadT            slots [Depth];                // Entry storage
  logic [PtrBits-1:0] rdPtr;
  logic [PtrBits-1:0] wrPtr;
  logic [CntBits-1:0] count;                        // Entries held
  logic               full;
  logic               doPop;

  function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
    return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign notEmpty = (count != '0);
  assign full     = (count == CntBits'(Depth));
  assign doPop    = pop && notEmpty;
  assign popData  = slots[rdPtr];                   // Head visible without a pop

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      rdPtr  <= '0;
      wrPtr  <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (doPop) rdPtr <= nextPtr(rdPtr);
      count  <= count + CntBits'(push) - CntBits'(doPop);
      credit <= doPop;                              // One pulse per freed slot
    end
  end

  always_ff @(posedge clock) begin
    if (push) slots[wrPtr] <= pushData;
  end

  // Sender must never push without a credit in hand
  assert property (@(posedge clock) disable iff (!resetN) push |-> !full)
    else $error("creditFifo push while full, credit protocol broken");

endmodule

// File: design/heapDispatch.sv
//--------------------------------------------------------------------------
// Request dispatcher with the array allocation bitmap
// Presets allocation errors and routes each request to its bank under credit
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module heapDispatch
  import heapOpsPkg::*;
  import heapLinkPkg::*;
#(
  parameter int NumBanks   = 4,
  parameter int QueueDepth = 4
) (
  input  logic                clock,
  input  logic                resetN,
  input  heapReq              inReq,
  input  logic                inNotEmpty,
  input  logic [NumBanks-1:0] bankCredit,
  output logic                inPop,
  output logic [NumBanks-1:0] bankValid,
  output bankReq              bankReqBus
);

  localparam int NumArrays = 1 << ArrayBits;
  localparam int CntBits   = $clog2(QueueDepth + 1);

  logic [NumArrays-1:0] allocated;                  // One bit per array
  logic [CntBits-1:0]   credits [NumBanks];         // Free slots per bank queue
  logic [ArrayBits-1:0] freeArray;                  // Lowest free array
  logic                 hasFree;
  bankReq               issueReq;
  int                   target;                     // Destination bank

  //--------------------------------------------------------------------------
  // Allocation lookup and request rewrite
  //--------------------------------------------------------------------------
  always_comb begin
    freeArray = '0;
    for (int i = NumArrays - 1; i >= 0; i--) begin
      if (!allocated[i]) freeArray = ArrayBits'(i);  // Lowest index wins
    end
    hasFree = ~&allocated;

    issueReq.req = inReq;
    issueReq.err = ErrNone;
    if (inReq.op == OpAlloc) begin
      if (hasFree) issueReq.req.array = freeArray;
      else issueReq.err = ErrNoMemory;
    end else if (!allocated[inReq.array]) begin
      issueReq.err = ErrNotAllocated;
    end

    // Failed allocs have no owning array, so bank 0 answers them
    target = (issueReq.err == ErrNoMemory) ? 0 : int'(issueReq.req.array) % NumBanks;
    inPop  = inNotEmpty && (credits[target] != '0);
  end

  //--------------------------------------------------------------------------
  // Bitmap, credit counters and issue
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      bankValid <= '0;
      for (int b = 0; b < NumBanks; b++) begin
        credits[b] <= CntBits'(QueueDepth);
      end
    end else begin
      if (inPop && issueReq.err == ErrNone) begin
        if (inReq.op == OpAlloc) allocated[freeArray] <= 1'b1;
        else if (inReq.op == OpFree) allocated[inReq.array] <= 1'b0;
      end
      for (int b = 0; b < NumBanks; b++) begin
        credits[b] <= credits[b] - CntBits'(inPop && target == b) + CntBits'(bankCredit[b]);
      end
      bankValid <= inPop ? (NumBanks'(1) << target) : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (inPop) bankReqBus <= issueReq;
  end

  // Banks may never return more credits than they were given
  for (genvar b = 0; b < NumBanks; b++) begin : gCreditCheck
    assert property (@(posedge clock) disable iff (!resetN)
      credits[b] <= CntBits'(QueueDepth))
      else $error("Bank %0d returned more credits than issued", b);
  end

endmodule

// File: design/arrayBank.sv
//--------------------------------------------------------------------------
// One bank of arrays: request queue, element storage, sizes
// and execution of one heap operation per cycle
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module arrayBank
  import heapOpsPkg::*;
  import heapLinkPkg::*;
#(
  parameter int NumBanks   = 4,
  parameter int QueueDepth = 4
) (
  input  logic   clock,
  input  logic   resetN,
  input  logic   reqValid,
  input  bankReq reqIn,
  input  logic   mergeCredit,
  output logic   bankCredit,
  output logic   rspValid,
  output heapRsp rspOut
);

  localparam int Slots = (1 << ArrayBits) / NumBanks;  // Arrays owned here

  bankReq               head;                      // Oldest queued request
  logic                 notEmpty;
  logic                 doOp;
  logic                 haveCredit;                // Single merge credit
  logic [DataBits-1:0]  store [Slots][ArrayLength];
  logic [IndexBits:0]   sizes [Slots];
  int                   slot;                      // Local array position
  logic [IndexBits:0]   curSize;
  logic [DataBits-1:0]  element;
  logic                 inBounds;
  logic                 wrEn;
  logic [IndexBits-1:0] wrIdx;
  logic [DataBits-1:0]  wrData;
  logic                 sizeEn;
  logic [IndexBits:0]   sizeNew;
  heapRsp               result;

  creditFifo #(.payloadT(bankReq), .Depth(QueueDepth)) u_queue (
    .clock    (clock),
    .resetN   (resetN),
    .push     (reqValid),
    .pushData (reqIn),
    .pop      (doOp),
    .popData  (head),
    .notEmpty (notEmpty),
    .credit   (bankCredit)
  );

  assign doOp = notEmpty && haveCredit;

  //--------------------------------------------------------------------------
  // Operation decode
  //--------------------------------------------------------------------------
  always_comb begin
    slot     = int'(head.req.array) / NumBanks;
    curSize  = sizes[slot];
    element  = store[slot][head.req.index];
    inBounds = {1'b0, head.req.index} < curSize;
    wrEn     = 1'b0;
    wrIdx    = head.req.index;
    wrData   = head.req.data;
    sizeEn   = 1'b0;
    sizeNew  = curSize;
    result.tag  = head.req.tag;
    result.data = '0;
    result.err  = head.err;                          // Preset errors pass straight back

    if (head.err == ErrNone) begin
      case (head.req.op)
        OpAlloc: begin
          sizeEn      = 1'b1;
          sizeNew     = '0;
          result.data = DataBits'(head.req.array);
        end
        OpWrite: begin
          wrEn        = 1'b1;
          result.data = head.req.data;
          if (!inBounds) begin                       // Grow to cover the index
            sizeEn  = 1'b1;
            sizeNew = {1'b0, head.req.index} + 1'b1;
          end
        end
        OpRead: begin
          if (inBounds) result.data = element;
          else result.err = ErrBounds;
        end
        OpSize: result.data = DataBits'(curSize);
        OpPush: begin
          if (curSize < ArrayLength) begin
            wrEn        = 1'b1;
            wrIdx       = curSize[IndexBits-1:0];
            sizeEn      = 1'b1;
            sizeNew     = curSize + 1'b1;
            result.data = head.req.data;
          end else begin
            result.err = ErrFull;
          end
        end
        OpPop: begin
          if (curSize != '0) begin
            sizeEn      = 1'b1;
            sizeNew     = curSize - 1'b1;
            result.data = store[slot][sizeNew[IndexBits-1:0]];
          end else begin
            result.err = ErrEmpty;
          end
        end
        OpAdd: begin
          if (inBounds) begin
            wrEn        = 1'b1;
            wrData      = element + head.req.data;   // Wraps at DataBits
            result.data = wrData;
          end else begin
            result.err = ErrBounds;
          end
        end
        default: ;                                   // Free only clears the bitmap
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // State update and response
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      haveCredit <= 1'b1;
      rspValid   <= 1'b0;
      for (int s = 0; s < Slots; s++) begin
        sizes[s] <= '0;
      end
    end else begin
      rspValid <= doOp;
      if (doOp) haveCredit <= 1'b0;
      else if (mergeCredit) haveCredit <= 1'b1;
      if (doOp && sizeEn) sizes[slot] <= sizeNew;
    end
  end

  always_ff @(posedge clock) begin
    if (doOp && wrEn) store[slot][wrIdx] <= wrData;
    if (doOp) rspOut <= result;
  end

  // Merger holds one response per bank, so a credit comes back only once spent
  assert property (@(posedge clock) disable iff (!resetN) mergeCredit |-> !haveCredit)
    else $error("Merge credit returned while the bank already holds one");

endmodule

// File: design/responseMerge.sv
//--------------------------------------------------------------------------
// Round-robin merge of bank responses onto the external response port
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module responseMerge
  import heapLinkPkg::*;
#(
  parameter int NumBanks   = 4,
  parameter int QueueDepth = 4
) (
  input  logic                clock,
  input  logic                resetN,
  input  logic [NumBanks-1:0] mergeValid,
  input  heapRsp              mergeRsp [NumBanks],
  input  logic                rspCredit,
  output logic [NumBanks-1:0] mergeCredit,
  output logic                rspValid,
  output heapRsp              rsp
);

  localparam int CntBits = $clog2(QueueDepth + 1);

  logic [NumBanks-1:0] held;                         // Holding register occupied
  heapRsp              holdReg [NumBanks];
  logic [CntBits-1:0]  rspCredits;                   // External credits left
  int                  ptr;                          // Round-robin start
  int                  sel;
  logic                fwd;

  always_comb begin
    sel = 0;
    fwd = 1'b0;
    for (int k = NumBanks - 1; k >= 0; k--) begin    // Nearest to ptr wins
      if (held[(ptr + k) % NumBanks]) begin
        sel = (ptr + k) % NumBanks;
        fwd = 1'b1;
      end
    end
    fwd = fwd && (rspCredits != '0);
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      held        <= '0;
      ptr         <= 0;
      rspCredits  <= CntBits'(QueueDepth);
      rspValid    <= 1'b0;
      mergeCredit <= '0;
    end else begin
      held <= held | mergeValid;
      if (fwd) begin
        held[sel] <= 1'b0;
        ptr       <= (sel + 1) % NumBanks;
      end
      rspValid    <= fwd;
      mergeCredit <= fwd ? (NumBanks'(1) << sel) : '0;
      rspCredits  <= rspCredits - CntBits'(fwd) + CntBits'(rspCredit);
    end
  end

  always_ff @(posedge clock) begin
    for (int b = 0; b < NumBanks; b++) begin
      if (mergeValid[b]) holdReg[b] <= mergeRsp[b];
    end
    if (fwd) rsp <= holdReg[sel];
  end

endmodule

// File: design/heapTop.sv
//--------------------------------------------------------------------------
// Heap engine top level: input queue, dispatcher, array banks, merger
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module heapTop
  import heapLinkPkg::*;
#(
  parameter int NumBanks   = 4,
  parameter int QueueDepth = 4
) (
  input  logic   clock,
  input  logic   resetN,
  input  logic   reqValid,
  input  heapReq req,
  input  logic   rspCredit,
  output logic   reqCredit,
  output logic   rspValid,
  output heapRsp rsp
);

  heapReq              queueHead;
  logic                queueNotEmpty;
  logic                queuePop;
  logic [NumBanks-1:0] bankValid;
  logic [NumBanks-1:0] bankCredit;
  bankReq              bankReqBus;                   // Shared by all banks
  logic [NumBanks-1:0] mergeValid;
  logic [NumBanks-1:0] mergeCredit;
  heapRsp              mergeRsp [NumBanks];

  creditFifo #(.payloadT(heapReq), .Depth(QueueDepth)) u_inQueue (
    .clock    (clock),
    .resetN   (resetN),
    .push     (reqValid),
    .pushData (req),
    .pop      (queuePop),
    .popData  (queueHead),
    .notEmpty (queueNotEmpty),
    .credit   (reqCredit)
  );

  heapDispatch #(.NumBanks(NumBanks), .QueueDepth(QueueDepth)) u_dispatch (
    .clock      (clock),
    .resetN     (resetN),
    .inReq      (queueHead),
    .inNotEmpty (queueNotEmpty),
    .bankCredit (bankCredit),
    .inPop      (queuePop),
    .bankValid  (bankValid),
    .bankReqBus (bankReqBus)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gBank
    arrayBank #(.NumBanks(NumBanks), .QueueDepth(QueueDepth)) u_bank (
      .clock       (clock),
      .resetN      (resetN),
      .reqValid    (bankValid[b]),
      .reqIn       (bankReqBus),
      .mergeCredit (mergeCredit[b]),
      .bankCredit  (bankCredit[b]),
      .rspValid    (mergeValid[b]),
      .rspOut      (mergeRsp[b])
    );
  end

  responseMerge #(.NumBanks(NumBanks), .QueueDepth(QueueDepth)) u_merge (
    .clock       (clock),
    .resetN      (resetN),
    .mergeValid  (mergeValid),
    .mergeRsp    (mergeRsp),
    .rspCredit   (rspCredit),
    .mergeCredit (mergeCredit),
    .rspValid    (rspValid),
    .rsp         (rsp)
  );

endmodule

// File: verif/heapChecker.sv
//--------------------------------------------------------------------------
// Reference model of the array heap, fed from the request port
// Matches responses by tag and counts mismatches and protocol errors
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module heapChecker
  import heapOpsPkg::*;
  import heapLinkPkg::*;
(
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     reqValid,
  input  heapReq                   req,
  input  logic                     rspValid,
  input  heapRsp                   rsp,
  output int                       mismatches,
  output int                       protocolErrors,
  output int                       responses,
  output logic [(1<<TagBits)-1:0]  pending        // Tags awaiting a response
);

  localparam int NumArrays = 1 << ArrayBits;
  localparam int NumTags   = 1 << TagBits;

  logic [NumArrays-1:0] inUse;                     // Model allocation state
  int                   size [NumArrays];
  logic [DataBits-1:0]  mem [NumArrays][ArrayLength];
  logic                 known [NumArrays][ArrayLength];  // Element holds defined data
  heapRsp               expRsp [NumTags];
  logic                 expKnown [NumTags];        // Data field is predictable

  // Apply one request in issue order and store its expected response
  task automatic applyRequest(input heapReq r);
    heapRsp e;
    logic   k;
    int     a;
    int     i;
    a      = int'(r.array);
    i      = int'(r.index);
    e.tag  = r.tag;
    e.data = '0;
    e.err  = ErrNone;
    k      = 1'b1;
    if (r.op == OpAlloc) begin
      if (&inUse) begin
        e.err = ErrNoMemory;
      end else begin
        a = 0;
        while (inUse[a]) a++;                      // Lowest free array
        inUse[a] = 1'b1;
        size[a]  = 0;
        e.data   = DataBits'(a);
      end
    end else if (!inUse[a]) begin
      e.err = ErrNotAllocated;
    end else begin
      case (r.op)
        OpFree: inUse[a] = 1'b0;
        OpWrite: begin
          mem[a][i]   = r.data;
          known[a][i] = 1'b1;
          if (i >= size[a]) size[a] = i + 1;
          e.data = r.data;
        end
        OpRead: begin
          if (i < size[a]) begin
            e.data = mem[a][i];
            k      = known[a][i];
          end else begin
            e.err = ErrBounds;
          end
        end
        OpSize: e.data = DataBits'(size[a]);
        OpPush: begin
          if (size[a] < ArrayLength) begin
            mem[a][size[a]]   = r.data;
            known[a][size[a]] = 1'b1;
            size[a]++;
            e.data = r.data;
          end else begin
            e.err = ErrFull;
          end
        end
        OpPop: begin
          if (size[a] > 0) begin
            size[a]--;
            e.data = mem[a][size[a]];
            k      = known[a][size[a]];
          end else begin
            e.err = ErrEmpty;
          end
        end
        OpAdd: begin
          if (i < size[a]) begin
            mem[a][i] = mem[a][i] + r.data;        // Wraps at 4096
            e.data    = mem[a][i];
            k         = known[a][i];
          end else begin
            e.err = ErrBounds;
          end
        end
        default: ;
      endcase
    end
    if (pending[r.tag]) begin
      $display("Time %0t: tag %0d reused before its response arrived", $time, r.tag);
      protocolErrors++;
    end
    pending[r.tag]  = 1'b1;
    expRsp[r.tag]   = e;
    expKnown[r.tag] = k;
  endtask

  // Compare one response with the stored expectation
  task automatic matchResponse(input heapRsp r);
    responses++;
    if (!pending[r.tag]) begin
      $display("Time %0t: response with tag %0d has no outstanding request", $time, r.tag);
      protocolErrors++;
    end else begin
      pending[r.tag] = 1'b0;
      if (r.err !== expRsp[r.tag].err) begin
        $display("Error time %0t: rsp.err tag %0d expected %0d actual %0d",
                 $time, r.tag, expRsp[r.tag].err, r.err);
        mismatches++;
      end
      if (expKnown[r.tag] && r.data !== expRsp[r.tag].data) begin
        $display("Error time %0t: rsp.data tag %0d expected 0x%03h actual 0x%03h",
                 $time, r.tag, expRsp[r.tag].data, r.data);
        mismatches++;
      end
    end
  endtask

  // Response first, so a tag freed and reissued in one cycle is handled in order
  always @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      inUse          = '0;
      pending        = '0;
      mismatches     = 0;
      protocolErrors = 0;
      responses      = 0;
      for (int a = 0; a < NumArrays; a++) begin
        size[a] = 0;
        for (int i = 0; i < ArrayLength; i++) begin
          known[a][i] = 1'b0;
        end
      end
    end else begin
      if (rspValid) matchResponse(rsp);
      if (reqValid) applyRequest(req);
    end
  end

endmodule

// File: verif/heapTb.sv
//--------------------------------------------------------------------------
// Testbench for the heap engine: clock, reset, directed and seeded random
// tagged requests, credit handling on both links and a cycle watchdog
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module heapTb
  import heapOpsPkg::*;
  import heapLinkPkg::*;
();

  localparam int NumBanks      = 4;
  localparam int QueueDepth    = 4;
  localparam int NumTags       = 1 << TagBits;
  localparam int RandomOps     = 1400;
  localparam int TimeoutCycles = 1500 * 40;       // Requests times cycles each

  logic               clock;
  logic               resetN;
  logic               reqValid;
  heapReq             req;
  logic               rspCredit;
  logic               reqCredit;
  logic               rspValid;
  heapRsp             rsp;
  int                 seed = 32'h0c13_434b;
  int                 cycleCount = 0;
  int                 reqCredits;                  // Credits held by the requester
  int                 owedCredits;                 // Responses not yet credited back
  int                 nextTag;
  logic [NumTags-1:0] busyTags;
  int                 creditErrors;
  int                 unanswered;
  int                 mismatches;
  int                 protocolErrors;
  int                 responses;
  logic [NumTags-1:0] pending;

  heapTop #(.NumBanks(NumBanks), .QueueDepth(QueueDepth)) u_dut (
    .clock     (clock),
    .resetN    (resetN),
    .reqValid  (reqValid),
    .req       (req),
    .rspCredit (rspCredit),
    .reqCredit (reqCredit),
    .rspValid  (rspValid),
    .rsp       (rsp)
  );

  heapChecker u_check (
    .clock          (clock),
    .resetN         (resetN),
    .reqValid       (reqValid),
    .req            (req),
    .rspValid       (rspValid),
    .rsp            (rsp),
    .mismatches     (mismatches),
    .protocolErrors (protocolErrors),
    .responses      (responses),
    .pending        (pending)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                     // 4 ns period
  end

  always @(posedge clock) cycleCount <= cycleCount + 1;

  initial begin : watchdog
    wait (cycleCount >= TimeoutCycles);
    $display("Timeout: test did not finish within %0d cycles", TimeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

  // ------------------------------------------------------------------------
  // One falling edge: take credits and responses, then send if allowed
  // ------------------------------------------------------------------------
  task automatic stepCycle(input logic want, input heapReq r, output logic sent);
    int t;
    @(negedge clock);
    reqValid  = 1'b0;
    rspCredit = 1'b0;
    sent      = 1'b0;
    if (reqCredit) reqCredits++;
    if (reqCredits > QueueDepth) begin
      $display("Time %0t: requester holds %0d credits, above the queue depth",
               $time, reqCredits);
      creditErrors++;
    end
    if (rspValid) begin
      busyTags[rsp.tag] = 1'b0;
      owedCredits++;
      if (owedCredits > QueueDepth) begin
        $display("Time %0t: response arrived with no response credit left", $time);
        creditErrors++;
      end
    end
    if (owedCredits > 0 && ($random(seed) & 3) == 0) begin  // Random credit delay
      rspCredit = 1'b1;
      owedCredits--;
    end
    if (want && reqCredits > 0) begin
      for (int k = 0; k < NumTags && !sent; k++) begin
        t = (nextTag + k) % NumTags;
        if (!busyTags[t]) begin
          req         = r;
          req.tag     = TagBits'(t);
          reqValid    = 1'b1;
          busyTags[t] = 1'b1;
          reqCredits--;
          nextTag     = (t + 1) % NumTags;
          sent        = 1'b1;
        end
      end
    end
  endtask

  task automatic sendReq(input heapOp op, input int array, input int index, input int data);
    heapReq r;
    logic   sent;
    r.tag   = '0;
    r.op    = op;
    r.array = ArrayBits'(array);
    r.index = IndexBits'(index);
    r.data  = DataBits'(data);
    sent    = 1'b0;
    while (!sent) stepCycle(1'b1, r, sent);
  endtask

  task automatic randomRequest();
    int    pick;
    heapOp op;
    pick = $random(seed) & 31;
    if (pick < 2) op = OpAlloc;
    else if (pick < 4) op = OpFree;
    else if (pick < 10) op = OpWrite;
    else if (pick < 15) op = OpRead;
    else if (pick < 17) op = OpSize;
    else if (pick < 22) op = OpPush;
    else if (pick < 27) op = OpPop;
    else op = OpAdd;
    sendReq(op, $random(seed) & 15, $random(seed) & 7, $random(seed) & 12'hfff);
  endtask

  // Wait until every response is in and every credit is back home
  task automatic drain();
    heapReq idle;
    logic   sent;
    idle = '0;
    stepCycle(1'b0, idle, sent);
    while (busyTags != '0 || owedCredits != 0 || reqCredits != QueueDepth) begin
      stepCycle(1'b0, idle, sent);
    end
    repeat (2) stepCycle(1'b0, idle, sent);
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    reqValid     = 1'b0;
    req          = '0;
    rspCredit    = 1'b0;
    resetN       = 1'b0;
    reqCredits   = QueueDepth;
    owedCredits  = 0;
    nextTag      = 0;
    busyTags     = '0;
    creditErrors = 0;
    unanswered   = 0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;

    for (int a = 0; a < 17; a++) sendReq(OpAlloc, 0, 0, 0);  // Last one has no room

    sendReq(OpWrite, 1, 0, 12'h123);
    sendReq(OpWrite, 1, 3, 12'h456);
    sendReq(OpRead, 1, 3, 0);
    sendReq(OpRead, 1, 0, 0);
    sendReq(OpRead, 1, 4, 0);                      // At the size
    sendReq(OpRead, 1, 7, 0);
    sendReq(OpSize, 1, 0, 0);

    for (int k = 0; k < 9; k++) sendReq(OpPush, 2, 0, 12'h100 + k);
    for (int k = 0; k < 9; k++) sendReq(OpPop, 2, 0, 0);

    sendReq(OpWrite, 3, 0, 12'hff0);
    sendReq(OpAdd, 3, 0, 12'h020);                 // Wraps past 4095
    sendReq(OpRead, 3, 0, 0);
    sendReq(OpAdd, 3, 5, 12'h001);

    sendReq(OpWrite, 5, 2, 12'h0cc);               // Nonzero size before the free
    sendReq(OpFree, 5, 0, 0);
    sendReq(OpWrite, 5, 0, 12'h0aa);
    sendReq(OpRead, 5, 0, 0);
    sendReq(OpSize, 5, 0, 0);
    sendReq(OpPush, 5, 0, 12'h0bb);
    sendReq(OpPop, 5, 0, 0);
    sendReq(OpAdd, 5, 0, 12'h001);
    sendReq(OpFree, 5, 0, 0);
    sendReq(OpAlloc, 0, 0, 0);
    sendReq(OpSize, 5, 0, 0);

    for (int n = 0; n < RandomOps; n++) randomRequest();
    drain();

    for (int t = 0; t < NumTags; t++) begin
      if (pending[t]) begin
        $display("Request with tag %0d never received a response", t);
        unanswered++;
      end
    end
    $display("Done: %0d responses, %0d mismatches, %0d protocol, %0d credit, %0d unanswered",
             responses, mismatches, protocolErrors, creditErrors, unanswered);
    if (mismatches + protocolErrors + creditErrors + unanswered == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
design/heapOpsPkg.sv
design/heapLinkPkg.sv
design/creditFifo.sv
design/heapDispatch.sv
design/arrayBank.sv
design/responseMerge.sv
design/heapTop.sv
verif/heapChecker.sv
verif/heapTb.sv

// File: run.sh
#!/bin/sh
# Build the heap testbench with Verilator and run it, logging to sim.log
verilator --binary --timing --assert --top-module heapTb -f tb.f -o heapSim \
  && ./obj_dir/heapSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "No pass message in log"; exit 1; }
exit 0
